/* noc_router.f */
rtl/noc_pkg.sv
rtl/noc_input_unit.sv
rtl/noc_rr_arbiter.sv
rtl/noc_switch_control.sv
rtl/noc_crossbar.sv
rtl/noc_router.sv
tests/noc_router_tb.sv

/* Makefile */
# Verilator simulation of the router testbench

VERILATOR ?= verilator
TOP       ?= noc_router_tb
FILELIST  ?= noc_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASSED

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/noc_router_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router_tb
  import noc_pkg::*;
();

  localparam int FIFO_DEPTH = 4;
  localparam int X_POS      = 2;
  localparam int Y_POS      = 2;
  // Flits driven at one input in the full FIFO test
  localparam int FULL_BURST = 6;
  // Output shared by two inputs in the arbitration test
  localparam int ARB_OUT    = 0;

  // One row of the stimulus table
  typedef struct packed {
    logic [2:0]           tid;
    logic                 vld;
    port_t                port;
    logic [COORD_W-1:0]   dest_x;
    logic [COORD_W-1:0]   dest_y;
    logic [PAYLOAD_W-1:0] payload;
    port_vec_t            en;
    logic                 grp_end;
    logic [7:0]           hold;
  } step_t;

  logic      clk = 1'b0;
  logic      reset_n;
  flit_arr_t i_flit;
  port_vec_t i_valid;
  port_vec_t i_en;
  port_vec_t o_en;
  flit_arr_t o_flit;
  port_vec_t o_valid;

  step_t     steps [$];
  // Expected flits in one queue per input and output pair
  flit_t     sb_q [NUM_PORTS*NUM_PORTS][$];
  port_vec_t en_at_edge = '1;
  int        seed;
  int        err_count = 0;
  int        test_errs = 0;
  int        pass_tests = 0;
  int        fail_tests = 0;
  int        rejected = 0;
  int        cur_tid = 0;
  int        last_src = -1;
  bit        all_out_seen = 1'b0;
  int        cycles = 0;
  int        cycle_limit = 0;

  always #2 clk = ~clk;

  noc_router #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .X_POS      (X_POS),
    .Y_POS      (Y_POS)
  ) i_dut (
    .clk     (clk),
    .reset_n (reset_n),
    .i_flit  (i_flit),
    .i_valid (i_valid),
    .o_en    (o_en),
    .i_en    (i_en),
    .o_flit  (o_flit),
    .o_valid (o_valid)
  );

  // ------------------------------------------------------------------------
  // Reference rules and helpers
  // ------------------------------------------------------------------------

  // XY rule tries X first, then Y, and falls back to local
  function automatic int route_xy(input logic [COORD_W-1:0] dx, input logic [COORD_W-1:0] dy);
    if (dx > COORD_W'(X_POS)) return int'(PORT_EAST);
    if (dx < COORD_W'(X_POS)) return int'(PORT_WEST);
    if (dy > COORD_W'(Y_POS)) return int'(PORT_NORTH);
    if (dy < COORD_W'(Y_POS)) return int'(PORT_SOUTH);
    return int'(PORT_LOCAL);
  endfunction

  function automatic bit all_queues_empty();
    for (int q = 0; q < NUM_PORTS * NUM_PORTS; q++) begin
      if (sb_q[q].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic string test_name(input int tid);
    case (tid)
      1:       return "reset";
      2:       return "routing";
      3:       return "arbitration";
      4:       return "back-pressure";
      5:       return "full fifo";
      6:       return "parallel traffic";
      default: return "unknown";
    endcase
  endfunction

  // Payload low byte is the row index, so every payload is unique
  task automatic add_step(input int tid, input bit vld, input port_t port, input int dx,
                          input int dy, input port_vec_t en, input bit grp_end, input int hold);
    step_t st;
    int    rnd;
    rnd        = $random(seed);
    st.tid     = 3'(tid);
    st.vld     = vld;
    st.port    = port;
    st.dest_x  = COORD_W'(dx);
    st.dest_y  = COORD_W'(dy);
    st.payload = {rnd[17:0], 8'(steps.size())};
    st.en      = en;
    st.grp_end = grp_end;
    st.hold    = 8'(hold);
    steps.push_back(st);
  endtask

  task automatic report_test(input int tid, input int errs);
    if (errs == 0) begin
      pass_tests++;
      $display("test %0d %s: pass", tid, test_name(tid));
    end else begin
      fail_tests++;
      $display("test %0d %s: fail, %0d errors", tid, test_name(tid), errs);
    end
  endtask

  task automatic begin_test(input int tid);
    cur_tid      = tid;
    test_errs    = err_count;
    rejected     = 0;
    last_src     = -1;
    all_out_seen = 1'b0;
  endtask

  // Drain every queue before the per-test checks
  task automatic finish_test(input int tid);
    int exp_rej;
    while (!all_queues_empty()) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    exp_rej = (tid == 5) ? FULL_BURST - FIFO_DEPTH : 0;
    if (rejected != exp_rej) begin
      $display("ERR o_en refusals exp %h got %h", exp_rej, rejected);
      err_count++;
    end
    if (tid == 6 && !all_out_seen) begin
      $display("Parallel traffic never had all five outputs valid in one cycle");
      err_count++;
    end
    report_test(tid, err_count - test_errs);
  endtask

  // ------------------------------------------------------------------------
  // Output monitor sampling mid-cycle where the registers are stable
  // ------------------------------------------------------------------------

  // Enable in force at the edge that launched the flit
  always @(posedge clk) begin
    en_at_edge <= i_en;
  end

  always @(negedge clk) begin : check_outputs
    int    src;
    int    qi;
    flit_t head_flit;
    flit_t exp_flit;
    if (o_valid == '1) begin
      all_out_seen = 1'b1;
    end
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (o_valid[o]) begin
        if (!en_at_edge[o]) begin
          $display("Output %0d launched a flit while its enable was low", o);
          err_count++;
        end
        // Source is the input whose queue front holds the same payload
        src = -1;
        for (int i = 0; i < NUM_PORTS; i++) begin
          qi = i * NUM_PORTS + o;
          if (src < 0 && sb_q[qi].size() > 0) begin
            head_flit = sb_q[qi][0];
            if (head_flit.payload == o_flit[o].payload) src = i;
          end
        end
        if (src < 0) begin
          $display("Output %0d delivered payload %h that no input had pending",
                   o, o_flit[o].payload);
          err_count++;
        end else begin
          exp_flit = sb_q[src * NUM_PORTS + o].pop_front();
          if (o_flit[o] !== exp_flit) begin
            $display("ERR o_flit[%0d] exp %h got %h", o, exp_flit, o_flit[o]);
            err_count++;
          end
          // Two busy inputs on one output must take turns
          if (cur_tid == 3 && o == ARB_OUT) begin
            if (src == last_src) begin
              $display("Output %0d served input %0d twice in a row", o, src);
              err_count++;
            end
            last_src = src;
          end
        end
      end
    end
  end

  // Run limit from the table length
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Run stopped after %0d cycles without draining", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin
    step_t st;
    flit_t f;
    reset_n = 1'b0;
    i_flit  = '0;
    i_valid = '0;
    i_en    = '1;
    seed    = 32'h40d139a9;

    // Routing covers one flit per direction plus one from another input
    add_step(2, 1'b1, PORT_LOCAL, 3, 2, 5'b11111, 1'b1, 1);
    add_step(2, 1'b1, PORT_LOCAL, 1, 2, 5'b11111, 1'b1, 1);
    add_step(2, 1'b1, PORT_LOCAL, 2, 3, 5'b11111, 1'b1, 1);
    add_step(2, 1'b1, PORT_LOCAL, 2, 1, 5'b11111, 1'b1, 1);
    add_step(2, 1'b1, PORT_LOCAL, 2, 2, 5'b11111, 1'b1, 1);
    add_step(2, 1'b1, PORT_WEST, 5, 0, 5'b11111, 1'b1, 1);
    // North and south inputs both send to local in the same cycle
    for (int k = 0; k < 4; k++) begin
      add_step(3, 1'b1, PORT_NORTH, 2, 2, 5'b11111, 1'b0, 0);
      add_step(3, 1'b1, PORT_SOUTH, 2, 2, 5'b11111, 1'b1, 0);
    end
    // East output blocked while the north output stays open
    for (int k = 0; k < 3; k++) begin
      add_step(4, 1'b1, PORT_LOCAL, 4, 1, 5'b11011, 1'b0, 0);
      add_step(4, 1'b1, PORT_WEST, 3, 3, 5'b11011, 1'b1, 0);
    end
    add_step(4, 1'b1, PORT_SOUTH, 2, 4, 5'b11011, 1'b1, 0);
    add_step(4, 1'b0, PORT_LOCAL, 0, 0, 5'b11011, 1'b1, 6);
    add_step(4, 1'b0, PORT_LOCAL, 0, 0, 5'b11111, 1'b1, 0);
    // East input floods the blocked north output
    for (int k = 0; k < FULL_BURST; k++) begin
      add_step(5, 1'b1, PORT_EAST, 2, 3, 5'b11101, 1'b1, 0);
    end
    add_step(5, 1'b0, PORT_LOCAL, 0, 0, 5'b11101, 1'b1, 3);
    add_step(5, 1'b0, PORT_LOCAL, 0, 0, 5'b11111, 1'b1, 0);
    // Five inputs to five distinct outputs at once
    for (int k = 0; k < 2; k++) begin
      add_step(6, 1'b1, PORT_LOCAL, 2, 3, 5'b11111, 1'b0, 0);
      add_step(6, 1'b1, PORT_NORTH, 2, 1, 5'b11111, 1'b0, 0);
      add_step(6, 1'b1, PORT_EAST, 1, 2, 5'b11111, 1'b0, 0);
      add_step(6, 1'b1, PORT_SOUTH, 3, 2, 5'b11111, 1'b0, 0);
      add_step(6, 1'b1, PORT_WEST, 2, 2, 5'b11111, 1'b1, 0);
    end
    cycle_limit = 20 * steps.size() + 200;

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Reset state
    begin_test(1);
    if (o_valid !== '0) begin
      $display("ERR o_valid exp %h got %h", 5'h00, o_valid);
      err_count++;
    end
    if (o_en !== '1) begin
      $display("ERR o_en exp %h got %h", 5'h1f, o_en);
      err_count++;
    end
    report_test(1, err_count - test_errs);

    // Rows of one group share a falling edge
    begin_test(int'(steps[0].tid));
    for (int s = 0; s < steps.size(); s++) begin
      st = steps[s];
      if (int'(st.tid) != cur_tid) begin
        finish_test(cur_tid);
        begin_test(int'(st.tid));
      end
      i_en = st.en;
      if (st.vld) begin
        f.dest_x          = st.dest_x;
        f.dest_y          = st.dest_y;
        f.payload         = st.payload;
        i_flit[st.port]   = f;
        i_valid[st.port]  = 1'b1;
        // Taken at the next edge only while the input has room
        if (o_en[st.port]) begin
          sb_q[int'(st.port) * NUM_PORTS + route_xy(st.dest_x, st.dest_y)].push_back(f);
        end else begin
          rejected++;
        end
      end
      if (st.grp_end) begin
        @(negedge clk);
        i_valid = '0;
        repeat (st.hold) @(negedge clk);
      end
    end
    finish_test(cur_tid);

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/noc_router.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_router
  import noc_pkg::*;
#(
  parameter int FIFO_DEPTH = 4,
  parameter int X_POS      = 2,
  parameter int Y_POS      = 2
) (
  input  wire logic      clk,
  input  wire logic      reset_n,

  // Inbound links, one per port
  input  wire flit_arr_t i_flit,
  input  wire port_vec_t i_valid,
  output      port_vec_t o_en,

  // Outbound links, i_en is the downstream enable
  input  wire port_vec_t i_en,
  output      flit_arr_t o_flit,
  output      port_vec_t o_valid
);

  // --------------------------------------------------------------------------
  // Internal wiring
  // --------------------------------------------------------------------------
  flit_arr_t head;
  port_mat_t req;
  port_mat_t grant;
  port_vec_t pop;

  // --------------------------------------------------------------------------
  // Input queues with route computation
  // --------------------------------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_input
    // Head-valid is folded into the request vector inside the unit
    noc_input_unit #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .X_POS      (X_POS),
      .Y_POS      (Y_POS)
    ) inst_input (
      .clk          (clk),
      .reset_n      (reset_n),
      .i_flit       (i_flit[p]),
      .i_valid      (i_valid[p]),
      .o_en         (o_en[p]),
      .i_pop        (pop[p]),
      .o_head       (head[p]),
      .o_head_valid (),
      .o_req        (req[p])
    );
  end

  // --------------------------------------------------------------------------
  // Switch allocation
  // --------------------------------------------------------------------------
  noc_switch_control inst_switch_control (
    .clk     (clk),
    .reset_n (reset_n),
    .i_req   (req),
    .i_en    (i_en),
    .o_grant (grant),
    .o_pop   (pop)
  );

  // --------------------------------------------------------------------------
  // Registered switch traversal
  // --------------------------------------------------------------------------
  noc_crossbar inst_crossbar (
    .clk     (clk),
    .reset_n (reset_n),
    .i_head  (head),
    .i_grant (grant),
    .o_flit  (o_flit),
    .o_valid (o_valid)
  );

endmodule

`default_nettype wire

/* rtl/noc_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_crossbar
  import noc_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset_n,

  // Head flit of every input queue
  input  wire flit_arr_t i_head,
  // Row o is the one-hot input selection of output o
  input  wire port_mat_t i_grant,

  // Registered outputs
  output      flit_arr_t o_flit,
  output      port_vec_t o_valid
);

  flit_arr_t sel_flit;
  port_vec_t any_grant;

  // --------------------------------------------------------------------------
  // Grant-steered selection
  // --------------------------------------------------------------------------

  // AND-OR mux, the grant row is one-hot or empty
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      sel_flit[o]  = '0;
      any_grant[o] = |i_grant[o];
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (i_grant[o][i]) begin
          sel_flit[o] = sel_flit[o] | i_head[i];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Output registers
  // --------------------------------------------------------------------------

  // Valid marks a flit launched in the grant cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_valid <= '0;
    end else begin
      o_valid <= any_grant;
    end
  end

  // Flit held between launches
  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (any_grant[o]) begin
        o_flit[o] <= sel_flit[o];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/noc_switch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_switch_control
  import noc_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset_n,

  // Row i holds the output requested by input i
  input  wire port_mat_t i_req,
  // Downstream enable per output
  input  wire port_vec_t i_en,

  // Row o holds the input granted by output o
  output      port_mat_t o_grant,
  // Input p won some output this cycle
  output      port_vec_t o_pop
);

  port_mat_t out_req;
  port_mat_t grant_by_input;

  // --------------------------------------------------------------------------
  // Transpose to output-major and mask by downstream enable
  // --------------------------------------------------------------------------
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        out_req[o][i] = i_req[i][o] && i_en[o];
      end
    end
  end

  // --------------------------------------------------------------------------
  // One round-robin arbiter per output
  // --------------------------------------------------------------------------
  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out_arb
    noc_rr_arbiter inst_arb (
      .clk     (clk),
      .reset_n (reset_n),
      .i_req   (out_req[o]),
      .o_grant (o_grant[o])
    );
  end

  // Back to input-major for the pop vector
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        grant_by_input[i][o] = o_grant[o][i];
      end
    end
  end

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_pop
    assign o_pop[i] = |grant_by_input[i];

    // One-hot routing means no input can win two outputs at once
    a_single_output : assert property (
      @(posedge clk) disable iff (!reset_n) $onehot0(grant_by_input[i])
    );
  end

endmodule

`default_nettype wire

/* rtl/noc_rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_rr_arbiter
  import noc_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset_n,
  input  wire port_vec_t i_req,
  output      port_vec_t o_grant
);

  localparam int IDX_W = $clog2(NUM_PORTS);

  // Highest priority input for the next grant
  logic [IDX_W-1:0] ptr;
  logic [IDX_W-1:0] winner;

  // Scan from the pointer, wrapping, first request wins
  always_comb begin : find_winner
    int idx;
    o_grant = '0;
    winner  = ptr;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = (int'(ptr) + k) % NUM_PORTS;
      if ((o_grant == '0) && i_req[idx]) begin
        o_grant[idx] = 1'b1;
        winner       = IDX_W'(idx);
      end
    end
  end

  // Winner drops to lowest priority after its grant
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ptr <= '0;
    end else if (o_grant != '0) begin
      if (winner == IDX_W'(NUM_PORTS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= winner + 1'b1;
      end
    end
  end

  // At most one winner, and only among the requesters
  a_grant_legal : assert property (
    @(posedge clk) disable iff (!reset_n)
      $onehot0(o_grant) && ((o_grant & ~i_req) == '0)
  );

endmodule

`default_nettype wire

/* rtl/noc_input_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_input_unit
  import noc_pkg::*;
#(
  parameter int FIFO_DEPTH = 4,
  parameter int X_POS      = 2,
  parameter int Y_POS      = 2
) (
  input  wire logic      clk,
  input  wire logic      reset_n,

  // Upstream side, valid/enable
  input  wire flit_t     i_flit,
  input  wire logic      i_valid,
  output      logic      o_en,

  // Head of queue towards the switch
  input  wire logic      i_pop,
  output      flit_t     o_head,
  output      logic      o_head_valid,
  output      port_vec_t o_req
);

  // Pointer width kept at least one bit for a depth of one
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // This router's place in the mesh
  localparam logic [COORD_W-1:0] X_COORD = COORD_W'(X_POS);
  localparam logic [COORD_W-1:0] Y_COORD = COORD_W'(Y_POS);

  flit_t              mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;

  // --------------------------------------------------------------------------
  // Circular FIFO
  // --------------------------------------------------------------------------

  // Accept only while there is room
  assign o_en = (count != CNT_W'(FIFO_DEPTH));
  assign push = i_valid && o_en;

  // Storage, no reset needed on the data
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_flit;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (i_pop) begin
        if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // Occupancy, unchanged on simultaneous push and pop
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count <= '0;
    end else begin
      case ({push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign o_head       = mem[rd_ptr];
  assign o_head_valid = (count != '0);

  // --------------------------------------------------------------------------
  // XY route computation on the head flit
  // --------------------------------------------------------------------------
  always_comb begin
    o_req = '0;
    if (o_head_valid) begin
      // X first, then Y, else deliver here
      if (o_head.dest_x > X_COORD) begin
        o_req[PORT_EAST] = 1'b1;
      end else if (o_head.dest_x < X_COORD) begin
        o_req[PORT_WEST] = 1'b1;
      end else if (o_head.dest_y > Y_COORD) begin
        o_req[PORT_NORTH] = 1'b1;
      end else if (o_head.dest_y < Y_COORD) begin
        o_req[PORT_SOUTH] = 1'b1;
      end else begin
        o_req[PORT_LOCAL] = 1'b1;
      end
    end
  end

  // Switch must only pop a queue that it saw requesting
  a_no_pop_when_empty : assert property (
    @(posedge clk) disable iff (!reset_n) i_pop |-> (count != '0)
  );

endmodule

`default_nettype wire

/* rtl/noc_pkg.sv */
`default_nettype none

package noc_pkg;

  // --------------------------------------------------------------------------
  // Router geometry
  // --------------------------------------------------------------------------

  // Five directions for XY routing, fixed by the mesh topology
  localparam int NUM_PORTS = 5;

  // Width of one mesh coordinate
  localparam int COORD_W = 3;

  // Flit is one 32-bit word, payload takes what the address leaves
  localparam int FLIT_W    = 32;
  localparam int PAYLOAD_W = FLIT_W - 2 * COORD_W;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  // Port directions, the value is also the index into every port vector
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_EAST  = 3'd2,
    PORT_SOUTH = 3'd3,
    PORT_WEST  = 3'd4
  } port_t;

  // Single-flit packet, destination in the upper bits
  typedef struct packed {
    logic [COORD_W-1:0]   dest_x;
    logic [COORD_W-1:0]   dest_y;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // One bit per port, for requests, enables, grants and pops
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // One row per port; input-major for requests, output-major for grants
  typedef port_vec_t [NUM_PORTS-1:0] port_mat_t;

  // One flit per port
  typedef flit_t [NUM_PORTS-1:0] flit_arr_t;

endpackage

`default_nettype wire
